// File: flag_core.f
design/arch_defs_pkg.sv
design/uop_stream_if.sv
design/instr_decoder.sv
design/uop_fifo.sv
design/alu.sv
design/status_logic_unit.sv
design/execute_stage.sv
design/flag_core_top.sv
dv/flag_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the testbench with the DUT and run it; $fatal gives a nonzero exit status
verilator --binary --timing --assert -j 0 \
    --top-module flag_core_tb \
    -f flag_core.f \
    -o flag_core_sim

./obj_dir/flag_core_sim

// File: dv/flag_core_tb.sv
`timescale 1ns/1ps

module flag_core_tb;

    import arch_defs_pkg::*;

    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_DIRECTED_MAX = 250;
    localparam int NUM_RANDOM       = 300;
    localparam int STALL_CYCLES     = 40;
    localparam int PATTERN_LEN      = 8192;
    // Twenty cycles per instruction plus reset and a margin for the drain
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + (NUM_DIRECTED_MAX + NUM_RANDOM) * 20 + 200;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    opcode_t               instr_opcode;
    logic [DATA_WIDTH-1:0] instr_operand_a;
    logic [DATA_WIDTH-1:0] instr_operand_b;
    logic                  instr_ready;
    logic                  result_ready;
    logic                  result_valid;
    logic [DATA_WIDTH-1:0] result_data;
    logic [DATA_WIDTH-1:0] status;

    // Expected beats as {result, status}, in instruction order
    logic [15:0]           exp_q[$];
    logic [15:0]           exp_beat;
    logic [DATA_WIDTH-1:0] model_status;
    logic                  ready_pattern [PATTERN_LEN];
    logic                  use_pattern;
    int                    pat_idx;
    int                    sent;
    int                    results_seen;
    logic                  saw_full;
    integer                seed;
    logic [31:0]           rnd;
    logic [DATA_WIDTH-1:0] vals [4];

    flag_core_top flag_core_top_inst (
        .clk             (clk),
        .rst             (rst),
        .instr_valid     (instr_valid),
        .instr_opcode    (instr_opcode),
        .instr_operand_a (instr_operand_a),
        .instr_operand_b (instr_operand_b),
        .instr_ready     (instr_ready),
        .result_ready    (result_ready),
        .result_valid    (result_valid),
        .result_data     (result_data),
        .status          (status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // Expected result and status for one instruction, built from the flag rules
    function automatic logic [15:0] model_step(input logic [DATA_WIDTH-1:0] st,
                                               input opcode_t op,
                                               input logic [DATA_WIDTH-1:0] a,
                                               input logic [DATA_WIDTH-1:0] b);
        logic       ci;
        logic       c;
        logic       z;
        logic       n;
        logic       upd_zn;
        logic       borrow;
        logic [7:0] r;
        logic [8:0] s;
        ci     = st[STATUS_CPU_CARRY];
        c      = ci;
        z      = st[STATUS_CPU_ZERO];
        n      = st[STATUS_CPU_NEG];
        upd_zn = 1'b1;
        r      = 8'h00;
        borrow = !ci;
        case (op)
            // Loads leave a zero result and keep C
            LDI_A, LDI_B, LDI_C: begin
                z      = (b == 8'h00);
                n      = b[7];
                upd_zn = 1'b0;
            end
            LDA, PLA: begin
                z      = (a == 8'h00);
                n      = a[7];
                upd_zn = 1'b0;
            end
            ADD: begin
                s = {1'b0, a} + {1'b0, b};
                r = s[7:0];
                c = s[8];
            end
            ADC: begin
                s = {1'b0, a} + {1'b0, b} + {8'h00, ci};
                r = s[7:0];
                c = s[8];
            end
            // Carry after a subtract means there was no borrow
            SUB: begin
                r = a - b;
                c = (a >= b);
            end
            SBC: begin
                r = a - b - {7'h00, borrow};
                c = ({1'b0, a} >= ({1'b0, b} + {8'h00, borrow}));
            end
            ROL: begin
                r = {a[6:0], ci};
                c = a[7];
            end
            ROR: begin
                r = {ci, a[7:1]};
                c = a[0];
            end
            AND_OP: begin
                r = a & b;
                c = 1'b0;
            end
            OR_OP: begin
                r = a | b;
                c = 1'b0;
            end
            XOR_OP: begin
                r = a ^ b;
                c = 1'b0;
            end
            INV: begin
                r = ~a;
                c = 1'b0;
            end
            INR: r = a + 8'd1;
            DCR: r = a - 8'd1;
            SEC: begin
                c      = 1'b1;
                upd_zn = 1'b0;
            end
            CLC: begin
                c      = 1'b0;
                upd_zn = 1'b0;
            end
            default: upd_zn = 1'b0;
        endcase
        if (upd_zn) begin
            z = (r == 8'h00);
            n = r[7];
        end
        return {r, 5'b00000, n, z, c};
    endfunction

    // Called just after a rising edge; returns just after the edge that took the beat
    task automatic send(input opcode_t op, input logic [7:0] a, input logic [7:0] b);
        logic [15:0] exp;
        instr_valid     = 1'b1;
        instr_opcode    = op;
        instr_operand_a = a;
        instr_operand_b = b;
        @(negedge clk);
        while (!instr_ready) begin
            @(negedge clk);
        end
        // The beat moves on the coming edge, so the model advances now
        exp          = model_step(model_status, op, a, b);
        model_status = exp[7:0];
        exp_q.push_back(exp);
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Result side back-pressure, driven just after each edge
    always @(posedge clk) begin
        #1;
        if (use_pattern) begin
            result_ready = ready_pattern[pat_idx];
            if (pat_idx < PATTERN_LEN - 1) begin
                pat_idx++;
            end
        end else begin
            result_ready = 1'b1;
        end
    end

    // Outputs are sampled at the falling edge where they are settled
    always @(negedge clk) begin
        if (!rst && !instr_ready) begin
            saw_full = 1'b1;
        end
        if (!rst && result_valid && result_ready) begin
            assert (exp_q.size() > 0)
                else fail_run("A result beat arrived with no instruction outstanding");
            exp_beat = exp_q.pop_front();
            assert (result_data == exp_beat[15:8] && status == exp_beat[7:0])
                else fail_run($sformatf(
                    "MISMATCH at %0t: beat %0d got result %h status %h, expected %h %h",
                    $time, results_seen, result_data, status, exp_beat[15:8], exp_beat[7:0]));
            results_seen++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("Timeout: not all results arrived within the allowed time");
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        instr_valid     = 1'b0;
        instr_opcode    = NOP;
        instr_operand_a = 8'h00;
        instr_operand_b = 8'h00;
        result_ready    = 1'b1;
        use_pattern     = 1'b0;
        pat_idx         = 0;
        sent            = 0;
        results_seen    = 0;
        saw_full        = 1'b0;
        model_status    = 8'h00;
        seed            = 32'h540a_ab4b;
        vals            = '{8'h00, 8'h80, 8'h7f, 8'h01};
        // A long stall first fills the pipeline, then ready toggles at random
        for (int i = 0; i < PATTERN_LEN; i++) begin
            rnd              = $random(seed);
            ready_pattern[i] = (i >= STALL_CYCLES) && rnd[0];
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (status == 8'h00 && !result_valid)
            else fail_run("After reset status is not zero or result_valid is high");
        assert (instr_ready)
            else fail_run("instr_ready is low in the first cycle after reset");
        @(posedge clk);
        #1;

        // Loads with C set and then clear
        send(SEC, 8'h00, 8'h00);
        foreach (vals[i]) begin
            send(LDI_A, 8'h5a, vals[i]);
            send(LDI_B, ~vals[i], vals[i]);
            send(LDI_C, 8'h00, vals[i]);
            send(LDA, vals[i], ~vals[i]);
            send(PLA, vals[i], 8'h00);
        end
        send(CLC, 8'h00, 8'h00);
        send(LDA, 8'h80, 8'h00);
        send(LDI_A, 8'hff, 8'h00);

        // Arithmetic and rotates with both carry-in values
        for (int cin = 0; cin < 2; cin++) begin
            foreach (vals[i]) begin
                for (int k = 0; k < 6; k++) begin
                    send(cin ? SEC : CLC, 8'h00, 8'h00);
                    send(opcode_t'(5'(int'(ADD) + k)), vals[i] ^ 8'h90, vals[3 - i]);
                end
            end
        end

        // Bitwise operations clear C
        for (int k = 0; k < 4; k++) begin
            send(SEC, 8'h00, 8'h00);
            send(opcode_t'(5'(int'(AND_OP) + k)), 8'hf0, 8'h0f);
            send(SEC, 8'h00, 8'h00);
            send(opcode_t'(5'(int'(AND_OP) + k)), 8'hff, 8'hff);
            send(SEC, 8'h00, 8'h00);
            send(opcode_t'(5'(int'(AND_OP) + k)), 8'h00, 8'h00);
        end

        // Steps keep C through the wraparound cases
        send(SEC, 8'h00, 8'h00);
        send(INR, 8'hff, 8'h00);
        send(INR, 8'h7f, 8'h00);
        send(DCR, 8'h00, 8'h00);
        send(DCR, 8'h80, 8'h00);
        send(CLC, 8'h00, 8'h00);
        send(INR, 8'hff, 8'h00);
        send(DCR, 8'h01, 8'h00);

        // SEC and CLC touch only C, NOP touches nothing
        send(LDI_A, 8'h00, 8'h80);
        send(SEC, 8'h12, 8'h34);
        send(NOP, 8'h56, 8'h78);
        send(CLC, 8'h9a, 8'hbc);
        send(NOP, 8'h00, 8'h00);
        send(LDI_A, 8'h00, 8'h00);
        send(SEC, 8'h00, 8'h00);
        send(NOP, 8'hff, 8'hff);
        send(CLC, 8'h00, 8'h00);

        // Random stream under result stalls and input gaps
        use_pattern = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            if (rnd[31:30] == 2'b00) begin
                idle(1 + int'(rnd[29:28]));
            end
            send(opcode_t'(5'(rnd[23:16] % 8'd20)), rnd[15:8], rnd[7:0]);
        end

        while (results_seen < sent) begin
            @(negedge clk);
        end
        if (exp_q.size() == 0 && saw_full) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("Run ended with results outstanding or without instr_ready ever dropping");
        end
    end

endmodule

// File: design/flag_core_top.sv
`timescale 1ns/1ps

module flag_core_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instr_valid,
    input  arch_defs_pkg::opcode_t               instr_opcode,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] instr_operand_a,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] instr_operand_b,
    output logic                                 instr_ready,
    input  logic                                 result_ready,
    output logic                                 result_valid,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] result_data,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] status
);

    import arch_defs_pkg::*;

    // Decoder to buffer stream
    uop_stream_if #(.payload_t(uop_t)) dec_to_fifo ();

    // Buffer to execute stream
    uop_stream_if #(.payload_t(uop_t)) fifo_to_exe ();

    // Registered decode of each accepted instruction
    instr_decoder instr_decoder_inst (
        .clk             (clk),
        .rst             (rst),
        .instr_valid     (instr_valid),
        .instr_opcode    (instr_opcode),
        .instr_operand_a (instr_operand_a),
        .instr_operand_b (instr_operand_b),
        .instr_ready     (instr_ready),
        .uop_out         (dec_to_fifo.source)
    );

    // Four entries of slack between decode and execute
    uop_fifo #(.payload_t(uop_t)) uop_fifo_inst (
        .clk  (clk),
        .rst  (rst),
        .push (dec_to_fifo.sink),
        .pop  (fifo_to_exe.source)
    );

    // ALU, flag update and the result beat
    execute_stage execute_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .result_ready (result_ready),
        .uop_in       (fifo_to_exe.sink),
        .result_valid (result_valid),
        .result_data  (result_data),
        .status       (status)
    );

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 result_ready,
    uop_stream_if.sink                           uop_in,
    output logic                                 result_valid,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] result_data,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] status
);

    import arch_defs_pkg::*;

    uop_t                  uop;
    logic                  take;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  alu_zero;
    logic                  alu_carry;
    logic                  alu_negative;
    logic                  zero_next;
    logic                  negative_next;
    logic                  carry_next;
    logic [DATA_WIDTH-1:0] status_next;

    assign uop = uop_in.payload;

    // The result slot frees up when empty or when its beat is taken this cycle
    assign uop_in.ready = !result_valid || result_ready;
    assign take         = uop_in.valid && uop_in.ready;

    // Carry in comes straight from the status register
    alu alu_inst (
        .alu_op_in        (uop.alu_op),
        .a_in             (uop.operand_a),
        .b_in             (uop.operand_b),
        .carry_in         (status[STATUS_CPU_CARRY]),
        .result_out       (alu_result),
        .alu_zero_out     (alu_zero),
        .alu_carry_out    (alu_carry),
        .alu_negative_out (alu_negative)
    );

    status_logic_unit status_logic_unit_inst (
        .alu_zero_in         (alu_zero),
        .alu_carry_in        (alu_carry),
        .alu_negative_in     (alu_negative),
        .load_sets_zn_in     (uop.load_sets_zn),
        .opcode_in           (uop.opcode),
        .temp_1_out_in       (uop.operand_b),
        .internal_bus_in     (uop.operand_a),
        .alu_op_in           (uop.alu_op),
        .current_status_in   (status),
        .set_carry_flag_in   (uop.set_carry),
        .clear_carry_flag_in (uop.clear_carry),
        .zero_flag_out       (zero_next),
        .negative_flag_out   (negative_next),
        .carry_flag_out      (carry_next)
    );

    // Pack the three flags into their status positions, other bits read zero
    always_comb begin
        status_next                   = '0;
        status_next[STATUS_CPU_CARRY] = carry_next;
        status_next[STATUS_CPU_ZERO]  = zero_next;
        status_next[STATUS_CPU_NEG]   = negative_next;
    end

    // Result slot and status register
    // Loads, SEC, CLC and NOP reach here with ALU_NONE, so their result is zero
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            result_data  <= '0;
            status       <= '0;
        end else begin
            if (take) begin
                result_valid <= 1'b1;
                result_data  <= alu_result;
                status       <= status_next;
            end else if (result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

endmodule

// File: design/status_logic_unit.sv
`timescale 1ns/1ps

module status_logic_unit (
    // Raw ALU flags
    input  logic                                 alu_zero_in,
    input  logic                                 alu_carry_in,
    input  logic                                 alu_negative_in,
    // Load indication and the opcode that picks the load source
    input  logic                                 load_sets_zn_in,
    input  arch_defs_pkg::opcode_t               opcode_in,
    // Immediate for LDI_x and internal bus for LDA and PLA
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] temp_1_out_in,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] internal_bus_in,
    input  arch_defs_pkg::alu_op_t               alu_op_in,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] current_status_in,
    // Explicit carry controls from SEC and CLC
    input  logic                                 set_carry_flag_in,
    input  logic                                 clear_carry_flag_in,
    output logic                                 zero_flag_out,
    output logic                                 negative_flag_out,
    output logic                                 carry_flag_out
);

    import arch_defs_pkg::*;

    // Data that a load places on the destination
    logic [DATA_WIDTH-1:0] load_data;

    // Pick the load source from the opcode
    always_comb begin
        case (opcode_in)
            LDI_A, LDI_B, LDI_C: load_data = temp_1_out_in;
            LDA, PLA:            load_data = internal_bus_in;
            default:             load_data = '0;
        endcase
    end

    // Next flag selection
    always_comb begin
        // Start from the present status so unlisted cases keep every flag
        zero_flag_out     = current_status_in[STATUS_CPU_ZERO];
        negative_flag_out = current_status_in[STATUS_CPU_NEG];
        carry_flag_out    = current_status_in[STATUS_CPU_CARRY];

        if (load_sets_zn_in) begin
            // Loads rewrite Z and N and never touch C
            zero_flag_out     = (load_data == '0);
            negative_flag_out = load_data[DATA_WIDTH-1];
        end else begin
            case (alu_op_in)
                // Arithmetic and rotates update all three flags
                ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_ROL, ALU_ROR: begin
                    zero_flag_out     = alu_zero_in;
                    negative_flag_out = alu_negative_in;
                    carry_flag_out    = alu_carry_in;
                end
                // Bitwise operations force C low
                ALU_AND, ALU_OR, ALU_XOR, ALU_INV: begin
                    zero_flag_out     = alu_zero_in;
                    negative_flag_out = alu_negative_in;
                    carry_flag_out    = 1'b0;
                end
                // Increment and decrement keep C
                ALU_INR, ALU_DCR: begin
                    zero_flag_out     = alu_zero_in;
                    negative_flag_out = alu_negative_in;
                end
                default: carry_flag_out = current_status_in[STATUS_CPU_CARRY];
            endcase
        end

        // SEC and CLC win over everything else for C
        if (set_carry_flag_in) begin
            carry_flag_out = 1'b1;
        end else if (clear_carry_flag_in) begin
            carry_flag_out = 1'b0;
        end
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  arch_defs_pkg::alu_op_t               alu_op_in,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] a_in,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] b_in,
    input  logic                                 carry_in,
    output logic [arch_defs_pkg::DATA_WIDTH-1:0] result_out,
    output logic                                 alu_zero_out,
    output logic                                 alu_carry_out,
    output logic                                 alu_negative_out
);

    import arch_defs_pkg::*;

    // One shared adder serves ADD, ADC, SUB and SBC
    logic [DATA_WIDTH-1:0] adder_b;
    logic                  adder_cin;
    logic [DATA_WIDTH:0]   adder_sum;

    // Subtraction is a plus the inverted b, so carry out means no borrow
    always_comb begin
        adder_b   = b_in;
        adder_cin = 1'b0;
        case (alu_op_in)
            ALU_ADC: adder_cin = carry_in;
            ALU_SUB: begin
                adder_b   = ~b_in;
                adder_cin = 1'b1;
            end
            // Borrow in is the inverse of C
            ALU_SBC: begin
                adder_b   = ~b_in;
                adder_cin = carry_in;
            end
            default: adder_cin = 1'b0;
        endcase
    end

    assign adder_sum = {1'b0, a_in} + {1'b0, adder_b} + {{DATA_WIDTH{1'b0}}, adder_cin};

    // Result and raw carry selection
    always_comb begin
        result_out    = '0;
        alu_carry_out = 1'b0;
        case (alu_op_in)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC: begin
                {alu_carry_out, result_out} = adder_sum;
            end
            // Rotates go through the carry bit
            ALU_ROL: begin
                result_out    = {a_in[DATA_WIDTH-2:0], carry_in};
                alu_carry_out = a_in[DATA_WIDTH-1];
            end
            ALU_ROR: begin
                result_out    = {carry_in, a_in[DATA_WIDTH-1:1]};
                alu_carry_out = a_in[0];
            end
            ALU_AND: result_out = a_in & b_in;
            ALU_OR:  result_out = a_in | b_in;
            ALU_XOR: result_out = a_in ^ b_in;
            ALU_INV: result_out = ~a_in;
            // Step carries are reported raw but the status unit ignores them
            ALU_INR: begin
                {alu_carry_out, result_out} = {1'b0, a_in} + 1'b1;
            end
            ALU_DCR: begin
                result_out    = a_in - 1'b1;
                alu_carry_out = (a_in != '0);
            end
            default: result_out = '0;
        endcase
    end

    assign alu_zero_out     = (result_out == '0);
    assign alu_negative_out = result_out[DATA_WIDTH-1];

endmodule

// File: design/uop_fifo.sv
`timescale 1ns/1ps

module uop_fifo #(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        rst,
    uop_stream_if.sink   push,
    uop_stream_if.source pop
);

    import arch_defs_pkg::*;

    // Circular storage
    payload_t mem [FIFO_DEPTH];

    // Pointers wrap naturally because the depth is a power of two
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    assign do_push = push.valid && push.ready;
    assign do_pop  = pop.valid && pop.ready;

    // Full blocks the writer even when a pop happens in the same cycle
    assign push.ready = (count != FIFO_CNT_W'(FIFO_DEPTH));

    // Head is driven purely from flops, so a new entry shows up one cycle after its push
    assign pop.valid   = (count != '0);
    assign pop.payload = mem[rd_ptr];

    // Pointer and occupancy tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count as it is
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.payload;
        end
    end

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                instr_valid,
    input  arch_defs_pkg::opcode_t              instr_opcode,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] instr_operand_a,
    input  logic [arch_defs_pkg::DATA_WIDTH-1:0] instr_operand_b,
    output logic                                instr_ready,
    uop_stream_if.source                        uop_out
);

    import arch_defs_pkg::*;

    // Decoded form of the instruction currently on the input pins
    uop_t dec_uop;

    // Output register and its occupancy flag
    uop_t uop_q;
    logic valid_q;

    // Map the opcode to its ALU operation and flag controls
    always_comb begin
        dec_uop.opcode       = instr_opcode;
        dec_uop.alu_op       = ALU_NONE;
        dec_uop.load_sets_zn = 1'b0;
        dec_uop.set_carry    = 1'b0;
        dec_uop.clear_carry  = 1'b0;
        dec_uop.operand_a    = instr_operand_a;
        dec_uop.operand_b    = instr_operand_b;

        case (instr_opcode)
            // All five loads take Z and N from their data source and keep C
            LDI_A, LDI_B, LDI_C, LDA, PLA: begin
                dec_uop.load_sets_zn = 1'b1;
            end
            ADD:    dec_uop.alu_op = ALU_ADD;
            ADC:    dec_uop.alu_op = ALU_ADC;
            SUB:    dec_uop.alu_op = ALU_SUB;
            SBC:    dec_uop.alu_op = ALU_SBC;
            ROL:    dec_uop.alu_op = ALU_ROL;
            ROR:    dec_uop.alu_op = ALU_ROR;
            AND_OP: dec_uop.alu_op = ALU_AND;
            OR_OP:  dec_uop.alu_op = ALU_OR;
            XOR_OP: dec_uop.alu_op = ALU_XOR;
            INV:    dec_uop.alu_op = ALU_INV;
            INR:    dec_uop.alu_op = ALU_INR;
            DCR:    dec_uop.alu_op = ALU_DCR;
            // Explicit carry controls leave the ALU idle
            SEC: begin
                dec_uop.set_carry = 1'b1;
            end
            CLC: begin
                dec_uop.clear_carry = 1'b1;
            end
            // NOP and any unused code become a micro-operation that changes nothing
            default: begin
                dec_uop.alu_op = ALU_NONE;
            end
        endcase
    end

    // The stage can accept when the register is empty or is being drained this cycle
    assign instr_ready = !valid_q || uop_out.ready;

    // Valid bit follows the input handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (instr_ready) begin
            valid_q <= instr_valid;
        end
    end

    // Payload only loads on an accepted instruction, so it holds while stalled
    always_ff @(posedge clk) begin
        if (instr_ready && instr_valid) begin
            uop_q <= dec_uop;
        end
    end

    assign uop_out.valid   = valid_q;
    assign uop_out.payload = uop_q;

endmodule

// File: design/uop_stream_if.sv
`timescale 1ns/1ps

interface uop_stream_if #(
    parameter type payload_t = logic
);

    // Handshake pair
    // A beat moves on a clock edge where both are high
    logic     valid;
    logic     ready;

    // Beat contents, held stable by the source while stalled
    payload_t payload;

    // Producer side of the stream
    modport source (
        output valid,
        output payload,
        input  ready
    );

    // Consumer side of the stream
    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// File: design/arch_defs_pkg.sv
package arch_defs_pkg;

    // Width of operands, results and the status register
    localparam int DATA_WIDTH = 8;

    // Micro-operation buffer depth
    // Keep it a power of two so the FIFO pointers wrap without extra logic
    localparam int FIFO_DEPTH = 4;

    // Pointer and occupancy widths derived from the depth
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Status register bit positions
    // Every bit above NEG reads zero
    localparam int STATUS_CPU_CARRY = 0;
    localparam int STATUS_CPU_ZERO  = 1;
    localparam int STATUS_CPU_NEG   = 2;

    // Instruction opcodes as they arrive at the top level
    typedef enum logic [4:0] {
        NOP    = 5'd0,
        LDI_A  = 5'd1,
        LDI_B  = 5'd2,
        LDI_C  = 5'd3,
        LDA    = 5'd4,
        PLA    = 5'd5,
        ADD    = 5'd6,
        ADC    = 5'd7,
        SUB    = 5'd8,
        SBC    = 5'd9,
        ROL    = 5'd10,
        ROR    = 5'd11,
        AND_OP = 5'd12,
        OR_OP  = 5'd13,
        XOR_OP = 5'd14,
        INV    = 5'd15,
        INR    = 5'd16,
        DCR    = 5'd17,
        SEC    = 5'd18,
        CLC    = 5'd19
    } opcode_t;

    // ALU operation select
    // ALU_NONE makes the ALU output a zero result
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_ADC  = 4'd2,
        ALU_SUB  = 4'd3,
        ALU_SBC  = 4'd4,
        ALU_ROL  = 4'd5,
        ALU_ROR  = 4'd6,
        ALU_AND  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_XOR  = 4'd9,
        ALU_INV  = 4'd10,
        ALU_INR  = 4'd11,
        ALU_DCR  = 4'd12
    } alu_op_t;

    // Decoded micro-operation passed from the decoder through the FIFO
    // operand_a doubles as the internal bus value and operand_b as the immediate
    typedef struct packed {
        opcode_t                opcode;
        alu_op_t                alu_op;
        logic                   load_sets_zn;
        logic                   set_carry;
        logic                   clear_carry;
        logic [DATA_WIDTH-1:0]  operand_a;
        logic [DATA_WIDTH-1:0]  operand_b;
    } uop_t;

endpackage
